// File: rtl/rename_pkg.sv
package rename_pkg;

	// Machine width
	localparam int slot_count = 2;

	// Register file sizes
	localparam int arch_reg_count = 32;
	localparam int phys_reg_count = 64;

	// Free list holds every tag not mapped after reset
	localparam int free_depth = 32;

	typedef logic [$clog2(arch_reg_count)-1:0] arch_reg_t;
	typedef logic [$clog2(phys_reg_count)-1:0] phys_tag_t;

	// One bit wider than the index so full and empty differ
	typedef logic [$clog2(free_depth):0] free_ptr_t;

	// Hardwired zero register, never renamed
	localparam arch_reg_t zero_reg = arch_reg_t'(arch_reg_count - 1);

	// Tag read by the zero register, always ready and never allocated
	localparam phys_tag_t reserved_tag = phys_tag_t'(phys_reg_count - 1);

	// Mapping of an architectural register right after reset
	function automatic phys_tag_t reset_tag(input int idx);
		if (idx == int'(zero_reg)) begin
			return reserved_tag;
		end
		return phys_tag_t'(idx);
	endfunction

endpackage

// File: rtl/rename_if.sv
`timescale 1ns/1ns

interface rename_if;
	import rename_pkg::*;

	logic [slot_count-1:0]      grant;     // All valid slots or none
	arch_reg_t [slot_count-1:0] src_a;
	arch_reg_t [slot_count-1:0] src_b;
	arch_reg_t [slot_count-1:0] dest;
	phys_tag_t [slot_count-1:0] new_tag;   // Tag popped for each slot

	// Free list side
	modport alloc (
		output grant,
		output new_tag
	);

	// Map table side
	modport rename (
		input grant,
		input src_a,
		input src_b,
		input dest,
		input new_tag
	);

	// Dispatch side, fed from the top-level ports
	modport source (
		output src_a,
		output src_b,
		output dest,
		input  grant,
		input  new_tag
	);

endinterface

// File: rtl/tag_cam.sv
`timescale 1ns/1ns

module tag_cam (
	input  logic [rename_pkg::slot_count-1:0]                      cdb_valid,
	input  rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0]     cdb_tag,
	input  rename_pkg::phys_tag_t [rename_pkg::arch_reg_count-1:0] entry_tag,
	output logic [rename_pkg::arch_reg_count-1:0]                  hit
);
	import rename_pkg::*;

	// Every entry against every live broadcast, matches ORed per entry
	always_comb begin
		hit = '0;
		for (int e = 0; e < arch_reg_count; e++) begin
			for (int s = 0; s < slot_count; s++) begin
				if (cdb_valid[s] && (cdb_tag[s] == entry_tag[e])) begin
					hit[e] = 1'b1;
				end
			end
		end
	end

endmodule

// File: rtl/map_table.sv
`timescale 1ns/1ns

module map_table (
	input  logic                                                   clock,
	input  logic                                                   reset,
	rename_if.rename                                               rn,
	input  logic [rename_pkg::slot_count-1:0]                      cdb_valid,
	input  rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0]     cdb_tag,
	input  logic                                                   branch_mispredict,
	input  rename_pkg::phys_tag_t [rename_pkg::arch_reg_count-1:0] restore_tag,
	input  logic [rename_pkg::arch_reg_count-1:0]                  restore_ready,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0]     src_a_tag,
	output logic [rename_pkg::slot_count-1:0]                      src_a_ready,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0]     src_b_tag,
	output logic [rename_pkg::slot_count-1:0]                      src_b_ready,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0]     old_tag,
	output rename_pkg::phys_tag_t [rename_pkg::arch_reg_count-1:0] next_tag,
	output logic [rename_pkg::arch_reg_count-1:0]                  next_ready
);
	import rename_pkg::*;

	phys_tag_t [arch_reg_count-1:0] map_tag;     // Current mapping
	logic [arch_reg_count-1:0]      map_ready;   // Value present in the physical register
	logic [arch_reg_count-1:0]      cam_hit;

	tag_cam u_cam (
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.entry_tag (map_tag),
		.hit       (cam_hit)
	);

	// Next state is built up in order: restore or CDB first, then slot 0, then slot 1.
	// Reads of a later slot therefore see the writes of earlier slots in the same group.
	always_comb begin
		if (branch_mispredict) begin
			next_tag   = restore_tag;     // Snapshot replaces everything, CDB dropped here
			next_ready = restore_ready;
		end else begin
			next_tag   = map_tag;
			next_ready = map_ready | cam_hit;
		end

		for (int s = 0; s < slot_count; s++) begin
			// Sources
			if (rn.src_a[s] == zero_reg) begin
				src_a_tag[s]   = reserved_tag;
				src_a_ready[s] = 1'b1;
			end else begin
				src_a_tag[s]   = next_tag[rn.src_a[s]];
				src_a_ready[s] = next_ready[rn.src_a[s]];
			end

			if (rn.src_b[s] == zero_reg) begin
				src_b_tag[s]   = reserved_tag;
				src_b_ready[s] = 1'b1;
			end else begin
				src_b_tag[s]   = next_tag[rn.src_b[s]];
				src_b_ready[s] = next_ready[rn.src_b[s]];
			end

			old_tag[s] = next_tag[rn.dest[s]];   // Goes to the ROB for freeing at retire

			// Destination write, the zero register keeps its reserved tag
			if (rn.grant[s] && !branch_mispredict && (rn.dest[s] != zero_reg)) begin
				next_tag[rn.dest[s]]   = rn.new_tag[s];
				next_ready[rn.dest[s]] = 1'b0;   // Result not produced yet
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_reg_count; i++) begin
				map_tag[i] <= reset_tag(i);   // Register i on tag i
			end
			map_ready <= '1;
		end else begin
			map_tag   <= next_tag;
			map_ready <= next_ready;
		end
	end

endmodule

// File: rtl/free_list.sv
`timescale 1ns/1ns

module free_list (
	input  logic                                               clock,
	input  logic                                               reset,
	input  logic [rename_pkg::slot_count-1:0]                  dispatch_valid,
	rename_if.alloc                                            rn,
	input  logic [rename_pkg::slot_count-1:0]                  retire_valid,
	input  rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] retire_tag,
	input  logic                                               branch_mispredict,
	input  rename_pkg::free_ptr_t                              restore_head,
	output rename_pkg::free_ptr_t                              head,
	output logic                                               dispatch_stall
);
	import rename_pkg::*;

	phys_tag_t                  fifo [free_depth];
	free_ptr_t                  head_q;
	free_ptr_t                  tail_q;
	free_ptr_t                  tail_next;
	free_ptr_t                  free_count;
	free_ptr_t                  need;        // Valid slots asking for a tag
	free_ptr_t [slot_count-1:0] wr_ptr;      // Tail slot of each retiring tag
	logic                       allocate;

	assign free_count = tail_q - head_q;

	// Slot s takes the tag after those of the valid slots before it
	always_comb begin
		free_ptr_t rd_ptr;
		need = '0;
		for (int s = 0; s < slot_count; s++) begin
			rd_ptr        = head_q + need;
			rn.new_tag[s] = fifo[rd_ptr[$clog2(free_depth)-1:0]];
			if (dispatch_valid[s]) begin
				need = need + 1'b1;
			end
		end
	end

	// Whole group or nothing keeps program order
	assign allocate       = !reset && (|dispatch_valid) && (free_count >= need)
		&& !branch_mispredict;
	assign rn.grant       = allocate ? dispatch_valid : '0;
	assign dispatch_stall = !reset && (|dispatch_valid) && !allocate;   // Quiet in reset

	// Head after this cycle and the value a checkpoint captures
	always_comb begin
		if (branch_mispredict) begin
			head = restore_head;
		end else if (allocate) begin
			head = head_q + need;
		end else begin
			head = head_q;
		end
	end

	// Retired tags pack in at the tail in slot order
	always_comb begin
		tail_next = tail_q;
		for (int s = 0; s < slot_count; s++) begin
			wr_ptr[s] = tail_next;
			if (retire_valid[s]) begin
				tail_next = tail_next + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < free_depth; i++) begin
				fifo[i] <= phys_tag_t'(arch_reg_count - 1 + i);   // Tags 31 to 62
			end
			head_q <= '0;
			tail_q <= free_ptr_t'(free_depth);   // Starts full
		end else begin
			for (int s = 0; s < slot_count; s++) begin
				if (retire_valid[s]) begin
					fifo[wr_ptr[s][$clog2(free_depth)-1:0]] <= retire_tag[s];
				end
			end
			head_q <= head;
			tail_q <= tail_next;
		end
	end

endmodule

// File: rtl/checkpoint_store.sv
`timescale 1ns/1ns

module checkpoint_store (
	input  logic                                                   clock,
	input  logic                                                   reset,
	input  logic                                                   checkpoint_take,
	input  rename_pkg::phys_tag_t [rename_pkg::arch_reg_count-1:0] next_tag,
	input  logic [rename_pkg::arch_reg_count-1:0]                  next_ready,
	input  rename_pkg::free_ptr_t                                  head,
	input  logic [rename_pkg::slot_count-1:0]                      cdb_valid,
	input  rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0]     cdb_tag,
	output rename_pkg::phys_tag_t [rename_pkg::arch_reg_count-1:0] restore_tag,
	output logic [rename_pkg::arch_reg_count-1:0]                  restore_ready,
	output rename_pkg::free_ptr_t                                  restore_head
);
	import rename_pkg::*;

	phys_tag_t [arch_reg_count-1:0] snap_tag;
	logic [arch_reg_count-1:0]      snap_ready;
	free_ptr_t                      snap_head;
	logic [arch_reg_count-1:0]      cam_hit;

	tag_cam u_cam (
		.cdb_valid (cdb_valid),
		.cdb_tag   (cdb_tag),
		.entry_tag (snap_tag),
		.hit       (cam_hit)
	);

	assign restore_tag   = snap_tag;
	assign restore_ready = snap_ready | cam_hit;   // Catches a broadcast in the restore cycle
	assign restore_head  = snap_head;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < arch_reg_count; i++) begin
				snap_tag[i] <= reset_tag(i);
			end
			snap_ready <= '1;
			snap_head  <= '0;
		end else if (checkpoint_take) begin
			snap_tag   <= next_tag;    // Map after this cycle's renames
			snap_ready <= next_ready;
			snap_head  <= head;
		end else begin
			// Results finishing after the branch stay visible on restore
			snap_ready <= snap_ready | cam_hit;
		end
	end

endmodule

// File: rtl/rename_stage.sv
`timescale 1ns/1ns

module rename_stage (
	input  logic                                               clock,
	input  logic                                               reset,
	input  logic [rename_pkg::slot_count-1:0]                  dispatch_valid,
	input  rename_pkg::arch_reg_t [rename_pkg::slot_count-1:0] src_a,
	input  rename_pkg::arch_reg_t [rename_pkg::slot_count-1:0] src_b,
	input  rename_pkg::arch_reg_t [rename_pkg::slot_count-1:0] dest,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] new_tag,
	output logic [rename_pkg::slot_count-1:0]                  grant,
	output logic                                               dispatch_stall,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] src_a_tag,
	output logic [rename_pkg::slot_count-1:0]                  src_a_ready,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] src_b_tag,
	output logic [rename_pkg::slot_count-1:0]                  src_b_ready,
	output rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] old_tag,
	input  logic [rename_pkg::slot_count-1:0]                  cdb_valid,
	input  rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] cdb_tag,
	input  logic [rename_pkg::slot_count-1:0]                  retire_valid,
	input  rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] retire_tag,
	input  logic                                               checkpoint_take,
	input  logic                                               branch_mispredict
);
	import rename_pkg::*;

	phys_tag_t [arch_reg_count-1:0] next_tag;
	logic [arch_reg_count-1:0]      next_ready;
	phys_tag_t [arch_reg_count-1:0] restore_tag;
	logic [arch_reg_count-1:0]      restore_ready;
	free_ptr_t                      head;
	free_ptr_t                      restore_head;

	rename_if rn ();

	// Dispatch bundle in and out of the interface
	assign rn.src_a = src_a;
	assign rn.src_b = src_b;
	assign rn.dest  = dest;
	assign grant    = rn.grant;
	assign new_tag  = rn.new_tag;

	free_list u_free_list (
		.clock             (clock),
		.reset             (reset),
		.dispatch_valid    (dispatch_valid),
		.rn                (rn.alloc),
		.retire_valid      (retire_valid),
		.retire_tag        (retire_tag),
		.branch_mispredict (branch_mispredict),
		.restore_head      (restore_head),
		.head              (head),
		.dispatch_stall    (dispatch_stall)
	);

	map_table u_map_table (
		.clock             (clock),
		.reset             (reset),
		.rn                (rn.rename),
		.cdb_valid         (cdb_valid),
		.cdb_tag           (cdb_tag),
		.branch_mispredict (branch_mispredict),
		.restore_tag       (restore_tag),
		.restore_ready     (restore_ready),
		.src_a_tag         (src_a_tag),
		.src_a_ready       (src_a_ready),
		.src_b_tag         (src_b_tag),
		.src_b_ready       (src_b_ready),
		.old_tag           (old_tag),
		.next_tag          (next_tag),
		.next_ready        (next_ready)
	);

	checkpoint_store u_checkpoint (
		.clock           (clock),
		.reset           (reset),
		.checkpoint_take (checkpoint_take),
		.next_tag        (next_tag),
		.next_ready      (next_ready),
		.head            (head),
		.cdb_valid       (cdb_valid),
		.cdb_tag         (cdb_tag),
		.restore_tag     (restore_tag),
		.restore_ready   (restore_ready),
		.restore_head    (restore_head)
	);

endmodule

// File: sim/rename_stage_assertions.sv
`timescale 1ns/1ns

module rename_stage_assertions (
	input logic                                               clock,
	input logic                                               reset,
	input logic [rename_pkg::slot_count-1:0]                  dispatch_valid,
	input logic [rename_pkg::slot_count-1:0]                  grant,
	input logic                                               dispatch_stall,
	input rename_pkg::arch_reg_t [rename_pkg::slot_count-1:0] src_a,
	input rename_pkg::arch_reg_t [rename_pkg::slot_count-1:0] src_b,
	input rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] src_a_tag,
	input rename_pkg::phys_tag_t [rename_pkg::slot_count-1:0] src_b_tag
);
	import rename_pkg::*;

	a_grant_needs_valid: assert property (@(posedge clock) disable iff (reset)
		(grant & ~dispatch_valid) == '0)
		else $error("grant on a slot without dispatch_valid");

	a_grant_or_stall: assert property (@(posedge clock) disable iff (reset)
		!((|grant) && dispatch_stall))
		else $error("grant and dispatch_stall high together");

	// Nothing active while reset is held
	a_quiet_in_reset: assert property (@(posedge clock)
		reset |-> ((grant == '0) && !dispatch_stall))
		else $error("output active during reset");

	for (genvar s = 0; s < slot_count; s++) begin : g_zero_reg
		a_zero_src_a: assert property (@(posedge clock) disable iff (reset)
			(src_a[s] == zero_reg) |-> (src_a_tag[s] == reserved_tag))
			else $error("zero register source a read a wrong tag");
		a_zero_src_b: assert property (@(posedge clock) disable iff (reset)
			(src_b[s] == zero_reg) |-> (src_b_tag[s] == reserved_tag))
			else $error("zero register source b read a wrong tag");
	end

endmodule

bind rename_stage rename_stage_assertions u_assertions (.*);

// File: sim/rename_stage_tb.sv
`timescale 1ns/1ns

module rename_stage_tb;
	import rename_pkg::*;

	localparam int field_count  = 28;   // Values per golden line
	localparam int max_lines    = 64;

	logic                       clock;
	logic                       reset;
	logic [slot_count-1:0]      dispatch_valid;
	arch_reg_t [slot_count-1:0] src_a;
	arch_reg_t [slot_count-1:0] src_b;
	arch_reg_t [slot_count-1:0] dest;
	phys_tag_t [slot_count-1:0] new_tag;
	logic [slot_count-1:0]      grant;
	logic                       dispatch_stall;
	phys_tag_t [slot_count-1:0] src_a_tag;
	logic [slot_count-1:0]      src_a_ready;
	phys_tag_t [slot_count-1:0] src_b_tag;
	logic [slot_count-1:0]      src_b_ready;
	phys_tag_t [slot_count-1:0] old_tag;
	logic [slot_count-1:0]      cdb_valid;
	phys_tag_t [slot_count-1:0] cdb_tag;
	logic [slot_count-1:0]      retire_valid;
	phys_tag_t [slot_count-1:0] retire_tag;
	logic                       checkpoint_take;
	logic                       branch_mispredict;

	logic [7:0] golden [max_lines*field_count];
	int         line;
	int         base;
	int         current_test;
	int         test_errors;
	int         tests_passed;
	int         tests_failed;

	rename_stage DUT (.*);

	always #20 clock = ~clock;

	task automatic check(input string name, input logic [7:0] actual,
		input logic [7:0] expected);
		if (actual !== expected) begin
			$display("mismatch %s on line %0d: got %h, expected %h",
				name, line, actual, expected);
			test_errors++;
		end
	endtask

	// Inputs come from the first 16 fields of a line
	task automatic drive_line(input int b);
		dispatch_valid    = golden[b+1][1:0];
		src_a[0]          = golden[b+2][4:0];
		src_a[1]          = golden[b+3][4:0];
		src_b[0]          = golden[b+4][4:0];
		src_b[1]          = golden[b+5][4:0];
		dest[0]           = golden[b+6][4:0];
		dest[1]           = golden[b+7][4:0];
		cdb_valid         = golden[b+8][1:0];
		cdb_tag[0]        = golden[b+9][5:0];
		cdb_tag[1]        = golden[b+10][5:0];
		retire_valid      = golden[b+11][1:0];
		retire_tag[0]     = golden[b+12][5:0];
		retire_tag[1]     = golden[b+13][5:0];
		checkpoint_take   = golden[b+14][0];
		branch_mispredict = golden[b+15][0];
	endtask

	task automatic check_line(input int b);
		check("grant", 8'(grant), golden[b+16]);
		check("dispatch_stall", 8'(dispatch_stall), golden[b+17]);
		check("new_tag[0]", 8'(new_tag[0]), golden[b+18]);
		check("new_tag[1]", 8'(new_tag[1]), golden[b+19]);
		check("src_a_tag[0]", 8'(src_a_tag[0]), golden[b+20]);
		check("src_a_tag[1]", 8'(src_a_tag[1]), golden[b+21]);
		check("src_a_ready", 8'(src_a_ready), golden[b+22]);
		check("src_b_tag[0]", 8'(src_b_tag[0]), golden[b+23]);
		check("src_b_tag[1]", 8'(src_b_tag[1]), golden[b+24]);
		check("src_b_ready", 8'(src_b_ready), golden[b+25]);
		check("old_tag[0]", 8'(old_tag[0]), golden[b+26]);
		check("old_tag[1]", 8'(old_tag[1]), golden[b+27]);
	endtask

	task automatic report_test(input int id);
		if (test_errors == 0) begin
			$display("test %0d passed", id);
			tests_passed++;
		end else begin
			$display("test %0d failed with %0d errors", id, test_errors);
			tests_failed++;
		end
		test_errors = 0;
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		dispatch_valid = '1;   // Requests held during reset must see no grant
		src_a = '0;
		src_b = '0;
		dest = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		retire_valid = '0;
		retire_tag = '0;
		checkpoint_take = 1'b0;
		branch_mispredict = 1'b0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		for (int i = 0; i < max_lines*field_count; i++) begin
			golden[i] = 8'hff;   // Marks lines past the end of the file
		end
		$readmemh("sim/rename_golden.txt", golden);

		repeat (3) @(posedge clock);
		#2 reset = 1'b0;
		dispatch_valid = '0;

		line = 0;
		current_test = int'(golden[0]);
		while (line < max_lines && golden[line*field_count] !== 8'hff) begin
			base = line * field_count;
			if (int'(golden[base]) != current_test) begin
				report_test(current_test);
				current_test = int'(golden[base]);
			end
			drive_line(base);
			#37;   // Just before the next rising edge
			check_line(base);
			@(posedge clock);
			#2;
			line++;
		end
		if (line == 0) begin
			$display("golden file held no stimulus lines");
			tests_failed++;
		end else begin
			report_test(current_test);
		end

		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: sim/rename_golden.txt
// In: test dv sa0 sa1 sb0 sb1 d0 d1 cdb_v cdb_t0 cdb_t1 ret_v ret_t0 ret_t1 take mispredict
// Out: grant stall nt0 nt1 sat0 sat1 sa_rdy sbt0 sbt1 sb_rdy old0 old1
1 0 05 1f 00 1e 00 00 0 00 00 0 00 00 0 0  0 0 1f 1f 05 3f 3 00 1e 3 00 00
1 0 1f 0a 1d 1f 01 02 0 00 00 0 00 00 0 0  0 0 1f 1f 3f 0a 3 1d 3f 3 01 02
2 3 01 03 02 04 03 04 0 00 00 0 00 00 0 0  3 0 1f 20 01 1f 1 02 04 3 03 04
2 3 03 05 04 06 05 05 0 00 00 0 00 00 0 0  3 0 21 22 1f 21 0 20 06 2 05 21
3 0 03 05 04 1f 00 00 1 1f 00 0 00 00 0 0  0 0 23 23 1f 22 1 20 3f 2 00 00
3 0 03 05 04 1f 00 00 2 00 22 0 00 00 0 0  0 0 23 23 1f 22 3 20 3f 2 00 00
4 1 04 00 05 00 06 00 0 00 00 0 00 00 1 0  1 0 23 24 20 00 2 22 00 3 06 00
4 3 06 03 1f 04 03 06 1 23 00 0 00 00 0 0  3 0 24 25 23 24 1 3f 20 1 1f 23
4 0 06 03 04 05 00 00 0 00 00 0 00 00 0 1  0 0 26 26 23 1f 3 20 22 2 00 00
4 3 06 03 0a 0a 0a 0b 0 00 00 0 00 00 0 0  3 0 24 25 23 1f 3 0a 24 1 0a 0b
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 26 27 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 28 29 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 2a 2b 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 2c 2d 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 2e 2f 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 30 31 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 32 33 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 34 35 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 36 37 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 38 39 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 3a 3b 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 3c 3d 3f 3f 3 3f 3f 3 3f 3f
5 1 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  1 0 3e 1f 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 3 03 04 0 0  0 1 1f 20 3f 3f 3 3f 3f 3 3f 3f
5 3 1f 1f 1f 1f 1f 1f 0 00 00 0 00 00 0 0  3 0 03 04 3f 3f 3 3f 3f 3 3f 3f

// File: rename_stage.f
rtl/rename_pkg.sv
rtl/rename_if.sv
rtl/tag_cam.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/checkpoint_store.sv
rtl/rename_stage.sv
sim/rename_stage_assertions.sv
sim/rename_stage_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = rename_stage_tb
FILELIST  = rename_stage.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
